// ==== compile.f ====
graph_cu_pkg.sv
vertex_port_if.sv
cu_io_regs.sv
cu_arbiter_control.sv
cu_vertex_unit.sv
cu_result_write.sv
cu_graph_control.sv
tb_clock_gen.sv
tb_cu_graph_assert.sv
tb_cu_graph.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the graph compute unit testbench with Verilator
verilator --binary --timing --assert --top-module tb_cu_graph -f compile.f -o tb_sim &&
	./obj_dir/tb_sim +verilator+error+limit+100 |
	awk '{ print } /^TEST PASS$/ { ok = 1 } END { exit !ok }' &&
	echo "Simulation passed" ||
	{ echo "Simulation failed"; exit 1; }

// ==== tb_cu_graph.sv ====
`timescale 1ns/10ps
/* Testbench for the graph compute unit control block
   Sends vertex jobs, models the edge memory and checks every result write */
module tb_cu_graph;
	import graph_cu_pkg::*;

	localparam int    NUM_VERTEX_CU  = 4;
	localparam int    TAG_W          = $clog2(NUM_VERTEX_CU);
	localparam int    NUM_JOBS       = 20;
	localparam addr_t CONFIG_BASE    = 32'h0040_0000;
	// Up to 15 edges per job at about 8 cycles each, plus dispatch and the disabled window
	localparam int    TIMEOUT_CYCLES = NUM_JOBS * 15 * 8 + 2600;

	logic             clock;
	logic             rstn;
	logic             enabled_in;
	logic [63:0]      cu_configure;
	logic             vertex_job_valid;
	vertex_id_t       vertex_job_id;
	degree_t          vertex_job_degree;
	addr_t            vertex_job_edge_base;
	logic             read_command_bus_grant;
	logic             read_data_valid;
	logic [TAG_W-1:0] read_data_tag;
	edge_data_t       read_data;
	logic             vertex_job_request;
	logic             read_command_bus_request;
	logic             read_command_valid;
	addr_t            read_command_address;
	logic [TAG_W-1:0] read_command_tag;
	logic             write_command_valid;
	addr_t            write_command_address;
	result_t          write_data;
	count_t           vertex_job_counter_done;
	count_t           edge_job_counter_done;

	logic [31:0]      rng_state = 32'd42;
	int               cycles = 0;
	int               checks = 0;
	int               errors = 0;
	int               writes = 0;
	logic             en_seen = 1'b0;
	count_t           degree_total = '0;
	result_t          exp_sum [vertex_id_t];
	addr_t            pend_addr [$];
	logic [TAG_W-1:0] pend_tag [$];
	int               pend_due [$];

	tb_clock_gen u_clock_gen (
		.clock(clock),
		.rstn (rstn )
	);

	cu_graph_control #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) dut (.*);

	// xorshift32, one step per call
	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Edge memory content
	function automatic edge_data_t model_value(input addr_t address);
		return address[15:0] ^ 16'h5A5A;
	endfunction

	function automatic result_t edge_sum(input addr_t base, input degree_t degree);
		result_t sum;
		sum = '0;
		for (int k = 0; k < int'(degree); k++) begin
			sum = sum + result_t'(model_value(base + addr_t'(k)));
		end
		return sum;
	endfunction

	task automatic check_write(input addr_t address, input result_t data);
		vertex_id_t id;
		id = vertex_id_t'(address - CONFIG_BASE);
		writes++;
		checks++;
		assert (exp_sum.exists(id) && address == CONFIG_BASE + addr_t'(id)) else begin
			errors++;
			$display("FAIL %0t: write to unexpected address %h", $time, address);
		end
		if (exp_sum.exists(id)) begin
			checks++;
			assert (data == exp_sum[id]) else begin
				errors++;
				$display("FAIL %0t: vertex %0d sum %0d, expected %0d",
					$time, id, data, exp_sum[id]);
			end
			// Each vertex is written once
			exp_sum.delete(id);
		end
	endtask

	task automatic end_run(input bit timed_out);
		$display("Checks %0d, errors %0d, assertion failures %0d, writes %0d of %0d",
			checks, errors, dut.u_assert.failures, writes, NUM_JOBS);
		if (timed_out || errors != 0 || dut.u_assert.failures != 0) begin
			$display("TEST FAIL");
		end else begin
			$display("TEST PASS");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Read memory model and write monitor
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		en_seen <= enabled_in;
	end

	// In-order responses after 1 to 4 cycles, tag echoed
	always @(negedge clock) begin
		if (read_command_valid) begin
			pend_addr.push_back(read_command_address);
			pend_tag.push_back(read_command_tag);
			pend_due.push_back(cycles + 1 + int'(next_random() % 32'd4));
		end
		// Responses wait while the DUT input stage is disabled
		if (en_seen && pend_due.size() > 0 && pend_due[0] <= cycles) begin
			read_data_valid = 1'b1;
			read_data_tag   = pend_tag.pop_front();
			read_data       = model_value(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end else begin
			read_data_valid = 1'b0;
		end
		read_command_bus_grant = (next_random() % 32'd4) != 32'd0;
		if (write_command_valid) begin
			check_write(write_command_address, write_data);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Job stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [31:0] rnd;
		vertex_id_t  id;
		degree_t     degree;
		addr_t       base;
		enabled_in             = 1'b1;
		cu_configure           = {32'h0000_0001, CONFIG_BASE};
		vertex_job_valid       = 1'b0;
		vertex_job_id          = '0;
		vertex_job_degree      = '0;
		vertex_job_edge_base   = '0;
		read_command_bus_grant = 1'b0;
		read_data_valid        = 1'b0;
		read_data_tag          = '0;
		read_data              = '0;
		@(posedge rstn);
		repeat (2) @(negedge clock);
		for (int i = 0; i < NUM_JOBS; i++) begin
			// A zero word must leave the latched base alone
			if (i == 6) begin
				cu_configure = '0;
			end
			if (i == 10) begin
				enabled_in = 1'b0;
				repeat (30) @(negedge clock);
				enabled_in = 1'b1;
			end
			while (!vertex_job_request) @(negedge clock);
			rnd    = next_random();
			id     = {rnd[10:0], 5'(i)};
			degree = degree_t'(next_random() % 32'd16);
			base   = next_random() & 32'h00FF_FFFF;
			exp_sum[id]  = edge_sum(base, degree);
			degree_total = degree_total + count_t'(degree);
			vertex_job_valid     = 1'b1;
			vertex_job_id        = id;
			vertex_job_degree    = degree;
			vertex_job_edge_base = base;
			@(negedge clock);
			vertex_job_valid = 1'b0;
			repeat (3) @(negedge clock);
		end
		while (writes < NUM_JOBS) @(negedge clock);
		repeat (2) @(negedge clock);
		checks = checks + 2;
		assert (vertex_job_counter_done == count_t'(NUM_JOBS)) else begin
			errors++;
			$display("FAIL %0t: vertex counter %0d, expected %0d",
				$time, vertex_job_counter_done, NUM_JOBS);
		end
		assert (edge_job_counter_done == degree_total) else begin
			errors++;
			$display("FAIL %0t: edge counter %0d, expected %0d",
				$time, edge_job_counter_done, degree_total);
		end
		end_run(1'b0);
	end

	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: not all results were written within %0d cycles", TIMEOUT_CYCLES);
		end_run(1'b1);
	end

endmodule

// ==== tb_cu_graph_assert.sv ====
`timescale 1ns/10ps
/* Protocol assertions for the graph compute unit control top level */
module tb_cu_graph_assert (
	input logic        clock,
	input logic        rstn,
	input logic        enabled_in,
	input logic        read_command_bus_grant,
	input logic        read_command_bus_request,
	input logic        read_command_valid,
	input logic        write_command_valid,
	input logic        vertex_job_request,
	input logic [31:0] vertex_job_counter_done,
	input logic [31:0] edge_job_counter_done
);

	int failures = 0;

	// Quiet outputs through reset and the first cycle after it
	a_reset_quiet: assert property (@(posedge clock)
		!rstn || !$past(rstn, 2) |-> !read_command_valid && !read_command_bus_request &&
			!write_command_valid && !vertex_job_request &&
			vertex_job_counter_done == 32'd0 && edge_job_counter_done == 32'd0)
	else begin
		failures++;
		$error("outputs or counters not cleared around reset");
	end

	// Input stage plus output stage puts the grant two samples back
	a_read_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		read_command_valid |-> $past(read_command_bus_grant, 2))
	else begin
		failures++;
		$error("read command without a bus grant two cycles earlier");
	end

	a_request_held: assert property (@(posedge clock) disable iff (!rstn)
		read_command_bus_request && !$past(read_command_bus_grant, 2)
			|=> read_command_bus_request)
	else begin
		failures++;
		$error("bus request dropped while a read was still pending");
	end

	////////////////////////////////////////////////////////////////////////////
	// Disabled window
	////////////////////////////////////////////////////////////////////////////

	a_disabled_no_read: assert property (@(posedge clock) disable iff (!rstn)
		!enabled_in && !$past(enabled_in) && !$past(enabled_in, 2)
			|-> !read_command_valid && !vertex_job_request)
	else begin
		failures++;
		$error("read command or job request while disabled");
	end

	// Results pass through two more registers before the write strobe
	a_disabled_no_write: assert property (@(posedge clock) disable iff (!rstn)
		!enabled_in && !$past(enabled_in) && !$past(enabled_in, 2) &&
			!$past(enabled_in, 3) && !$past(enabled_in, 4) |-> !write_command_valid)
	else begin
		failures++;
		$error("write command while disabled");
	end

endmodule

bind cu_graph_control tb_cu_graph_assert u_assert (
	.clock                   (clock                   ),
	.rstn                    (rstn                    ),
	.enabled_in              (enabled_in              ),
	.read_command_bus_grant  (read_command_bus_grant  ),
	.read_command_bus_request(read_command_bus_request),
	.read_command_valid      (read_command_valid      ),
	.write_command_valid     (write_command_valid     ),
	.vertex_job_request      (vertex_job_request      ),
	.vertex_job_counter_done (vertex_job_counter_done ),
	.edge_job_counter_done   (edge_job_counter_done   )
);

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
/* Testbench clock and reset, 20 ns period with reset held for 4 cycles */
module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD) clock = ~clock;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rstn = 1'b1;
	end

endmodule

// ==== cu_graph_control.sv ====
`timescale 1ns/10ps
/* Graph compute unit control top level
   Register stage, arbiter control, vertex units and result writer */
module cu_graph_control #(
	parameter  int NUM_VERTEX_CU = graph_cu_pkg::NUM_VERTEX_CU_DEFAULT,
	localparam int TAG_W         = $clog2(NUM_VERTEX_CU)
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     enabled_in,
	input  logic [63:0]              cu_configure,
	input  logic                     vertex_job_valid,
	input  graph_cu_pkg::vertex_id_t vertex_job_id,
	input  graph_cu_pkg::degree_t    vertex_job_degree,
	input  graph_cu_pkg::addr_t      vertex_job_edge_base,
	input  logic                     read_command_bus_grant,
	input  logic                     read_data_valid,
	input  logic [TAG_W-1:0]         read_data_tag,
	input  graph_cu_pkg::edge_data_t read_data,
	output logic                     vertex_job_request,
	output logic                     read_command_bus_request,
	output logic                     read_command_valid,
	output graph_cu_pkg::addr_t      read_command_address,
	output logic [TAG_W-1:0]         read_command_tag,
	output logic                     write_command_valid,
	output graph_cu_pkg::addr_t      write_command_address,
	output graph_cu_pkg::result_t    write_data,
	output graph_cu_pkg::count_t     vertex_job_counter_done,
	output graph_cu_pkg::count_t     edge_job_counter_done
);
	import graph_cu_pkg::*;

	logic             enabled;
	addr_t            config_base;
	vertex_job_t      job;
	logic             job_valid;
	logic             read_grant;
	logic             data_valid;
	logic [TAG_W-1:0] data_tag;
	edge_data_t       data;

	logic             job_request;
	logic             read_bus_request;
	logic             read_valid;
	addr_t            read_address;
	logic [TAG_W-1:0] read_tag;
	logic             result_valid;
	vertex_id_t       result_id;
	result_t          result;
	logic             result_write_valid;
	addr_t            result_write_address;
	result_t          result_write_data;
	count_t           vertex_done;
	count_t           edge_done;

	vertex_port_if port_if [NUM_VERTEX_CU] ();

	////////////////////////////////////////////////////////////////////////////
	// Register stage
	////////////////////////////////////////////////////////////////////////////

	cu_io_regs #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) u_io_regs (
		.clock                   (clock                   ),
		.rstn                    (rstn                    ),
		.enabled_in              (enabled_in              ),
		.cu_configure            (cu_configure            ),
		.vertex_job_valid        (vertex_job_valid        ),
		.vertex_job_id           (vertex_job_id           ),
		.vertex_job_degree       (vertex_job_degree       ),
		.vertex_job_edge_base    (vertex_job_edge_base    ),
		.read_command_bus_grant  (read_command_bus_grant  ),
		.read_data_valid         (read_data_valid         ),
		.read_data_tag           (read_data_tag           ),
		.read_data               (read_data               ),
		.enabled                 (enabled                 ),
		.config_base             (config_base             ),
		.job                     (job                     ),
		.job_valid               (job_valid               ),
		.read_grant              (read_grant              ),
		.data_valid              (data_valid              ),
		.data_tag                (data_tag                ),
		.data                    (data                    ),
		.job_request             (job_request             ),
		.read_bus_request        (read_bus_request        ),
		.read_valid              (read_valid              ),
		.read_address            (read_address            ),
		.read_tag                (read_tag                ),
		.result_write_valid      (result_write_valid      ),
		.result_write_address    (result_write_address    ),
		.result_write_data       (result_write_data       ),
		.vertex_done             (vertex_done             ),
		.edge_done               (edge_done               ),
		.vertex_job_request      (vertex_job_request      ),
		.read_command_bus_request(read_command_bus_request),
		.read_command_valid      (read_command_valid      ),
		.read_command_address    (read_command_address    ),
		.read_command_tag        (read_command_tag        ),
		.write_command_valid     (write_command_valid     ),
		.write_command_address   (write_command_address   ),
		.write_data              (write_data              ),
		.vertex_job_counter_done (vertex_job_counter_done ),
		.edge_job_counter_done   (edge_job_counter_done   )
	);

	////////////////////////////////////////////////////////////////////////////
	// Arbiter and vertex units
	////////////////////////////////////////////////////////////////////////////

	cu_arbiter_control #(
		.NUM_VERTEX_CU(NUM_VERTEX_CU)
	) u_arbiter_control (
		.clock           (clock           ),
		.rstn            (rstn            ),
		.enabled         (enabled         ),
		.job_valid       (job_valid       ),
		.job             (job             ),
		.read_grant      (read_grant      ),
		.data_valid      (data_valid      ),
		.data_tag        (data_tag        ),
		.data            (data            ),
		.units           (port_if         ),
		.job_request     (job_request     ),
		.read_bus_request(read_bus_request),
		.read_valid      (read_valid      ),
		.read_address    (read_address    ),
		.read_tag        (read_tag        ),
		.result_valid    (result_valid    ),
		.result_id       (result_id       ),
		.result          (result          ),
		.vertex_done     (vertex_done     ),
		.edge_done       (edge_done       )
	);

	for (genvar g = 0; g < NUM_VERTEX_CU; g++) begin : g_vertex_cu
		cu_vertex_unit u_vertex_unit (
			.clock(clock     ),
			.rstn (rstn      ),
			.port (port_if[g])
		);
	end

	cu_result_write u_result_write (
		.clock        (clock               ),
		.rstn         (rstn                ),
		.result_valid (result_valid        ),
		.result_id    (result_id           ),
		.result       (result              ),
		.config_base  (config_base         ),
		.write_valid  (result_write_valid  ),
		.write_address(result_write_address),
		.write_data   (result_write_data   )
	);

endmodule

// ==== cu_result_write.sv ====
`timescale 1ns/10ps
/* Result writer, turns an accepted vertex sum into a write command */
module cu_result_write (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     result_valid,
	input  graph_cu_pkg::vertex_id_t result_id,
	input  graph_cu_pkg::result_t    result,
	input  graph_cu_pkg::addr_t      config_base,
	output logic                     write_valid,
	output graph_cu_pkg::addr_t      write_address,
	output graph_cu_pkg::result_t    write_data
);
	import graph_cu_pkg::*;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_valid <= 1'b0;
		end else begin
			write_valid <= result_valid;
		end
	end

	// One result word per vertex id
	always_ff @(posedge clock) begin
		if (result_valid) begin
			write_address <= config_base + addr_t'(result_id);
			write_data    <= result;
		end
	end

endmodule

// ==== cu_vertex_unit.sv ====
`timescale 1ns/10ps
/* Vertex unit
   Reads the edges of one vertex job and sums the returned values */
module cu_vertex_unit (
	input logic         clock,
	input logic         rstn,
	vertex_port_if.unit port
);
	import graph_cu_pkg::*;

	vertex_state_e state;
	vertex_job_t   job_r;
	degree_t       edge_idx;
	degree_t       returned;
	degree_t       returned_next;
	result_t       sum;

	assign returned_next = returned + degree_t'(port.data_valid);

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state    <= IDLE;
			edge_idx <= '0;
			returned <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (port.job_valid) begin
						edge_idx <= '0;
						returned <= '0;
						// No edges means nothing to fetch
						state    <= (port.job.degree == '0) ? RESULT : FETCH;
					end
				end
				FETCH: begin
					returned <= returned_next;
					if (port.read_grant) begin
						edge_idx <= edge_idx + 1'b1;
						if (edge_idx == job_r.degree - 8'd1) begin
							state <= DRAIN;
						end
					end
				end
				DRAIN: begin
					returned <= returned_next;
					if (returned_next == job_r.degree) begin
						state <= RESULT;
					end
				end
				RESULT: begin
					if (port.result_grant) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Job record and running sum
	always_ff @(posedge clock) begin
		if (state == IDLE && port.job_valid) begin
			job_r <= port.job;
			sum   <= '0;
		end else if (port.data_valid) begin
			sum <= sum + result_t'(port.data);
		end
	end

	assign port.idle          = (state == IDLE);
	assign port.read_valid    = (state == FETCH);
	assign port.read_address  = job_r.edge_base + addr_t'(edge_idx);
	assign port.result_valid  = (state == RESULT);
	assign port.result        = sum;
	assign port.result_id     = job_r.id;
	assign port.result_degree = job_r.degree;

endmodule

// ==== cu_arbiter_control.sv ====
`timescale 1ns/10ps
/* Arbiter control for the vertex units
   Dispatches jobs, arbitrates reads and results, routes data, counts work */
module cu_arbiter_control #(
	parameter  int NUM_VERTEX_CU = graph_cu_pkg::NUM_VERTEX_CU_DEFAULT,
	localparam int TAG_W         = $clog2(NUM_VERTEX_CU)
) (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      enabled,
	input  logic                      job_valid,
	input  graph_cu_pkg::vertex_job_t job,
	input  logic                      read_grant,
	input  logic                      data_valid,
	input  logic [TAG_W-1:0]          data_tag,
	input  graph_cu_pkg::edge_data_t  data,
	vertex_port_if.arbiter            units [NUM_VERTEX_CU],
	output logic                      job_request,
	output logic                      read_bus_request,
	output logic                      read_valid,
	output graph_cu_pkg::addr_t       read_address,
	output logic [TAG_W-1:0]          read_tag,
	output logic                      result_valid,
	output graph_cu_pkg::vertex_id_t  result_id,
	output graph_cu_pkg::result_t     result,
	output graph_cu_pkg::count_t      vertex_done,
	output graph_cu_pkg::count_t      edge_done
);
	import graph_cu_pkg::*;

	logic [NUM_VERTEX_CU-1:0] idle;
	logic [NUM_VERTEX_CU-1:0] read_req;
	logic [NUM_VERTEX_CU-1:0] result_req;
	addr_t                    read_addr  [NUM_VERTEX_CU];
	result_t                  res_sum    [NUM_VERTEX_CU];
	vertex_id_t               res_id     [NUM_VERTEX_CU];
	degree_t                  res_degree [NUM_VERTEX_CU];

	logic [TAG_W-1:0] job_sel;
	logic [TAG_W-1:0] read_ptr;
	logic [TAG_W-1:0] read_pick;
	logic [TAG_W-1:0] result_ptr;
	logic [TAG_W-1:0] result_pick;
	logic             dispatch;
	logic             read_fire;
	logic             result_fire;
	logic [1:0]       cooldown;

	// First requester at or after the pointer
	function automatic logic [TAG_W-1:0] rr_pick(input logic [NUM_VERTEX_CU-1:0] req,
		input logic [TAG_W-1:0] ptr);
		logic [TAG_W-1:0] pick;
		logic [TAG_W-1:0] idx;
		logic             found;
		pick  = ptr;
		found = 1'b0;
		for (int k = 0; k < NUM_VERTEX_CU; k++) begin
			idx = TAG_W'(ptr + k);
			if (!found && req[idx]) begin
				pick  = idx;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Per-unit fan-out and fan-in
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < NUM_VERTEX_CU; g++) begin : g_unit
		assign idle[g]       = units[g].idle;
		assign read_req[g]   = units[g].read_valid;
		assign read_addr[g]  = units[g].read_address;
		assign result_req[g] = units[g].result_valid;
		assign res_sum[g]    = units[g].result;
		assign res_id[g]     = units[g].result_id;
		assign res_degree[g] = units[g].result_degree;

		assign units[g].job_valid    = dispatch && (job_sel == TAG_W'(g));
		assign units[g].job          = job;
		assign units[g].read_grant   = read_fire && (read_pick == TAG_W'(g));
		// Read data goes to the unit named by its tag
		assign units[g].data_valid   = data_valid && (data_tag == TAG_W'(g));
		assign units[g].data         = data;
		assign units[g].result_grant = result_fire && (result_pick == TAG_W'(g));
	end

	// Lowest-index idle unit takes the job
	always_comb begin
		job_sel = '0;
		for (int k = NUM_VERTEX_CU - 1; k >= 0; k--) begin
			if (idle[k]) begin
				job_sel = TAG_W'(k);
			end
		end
	end

	assign dispatch    = job_valid && (|idle);
	assign job_request = enabled && (|idle) && (cooldown == 2'd0) && !job_valid;

	// Read port, one grant per cycle while the bus grant is held
	assign read_pick        = rr_pick(read_req, read_ptr);
	assign read_fire        = enabled && read_grant && (|read_req);
	assign read_bus_request = |read_req;
	assign read_valid       = read_fire;
	assign read_address     = read_addr[read_pick];
	assign read_tag         = read_pick;

	assign result_pick = rr_pick(result_req, result_ptr);
	assign result_fire = enabled && (|result_req);

	////////////////////////////////////////////////////////////////////////////
	// Pointers, results and done counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_ptr     <= '0;
			result_ptr   <= '0;
			cooldown     <= 2'd0;
			result_valid <= 1'b0;
			vertex_done  <= '0;
			edge_done    <= '0;
		end else begin
			if (dispatch) begin
				cooldown <= 2'd3;
			end else if (cooldown != 2'd0) begin
				cooldown <= cooldown - 2'd1;
			end
			if (read_fire) begin
				read_ptr <= read_pick + 1'b1;
			end
			result_valid <= result_fire;
			if (result_fire) begin
				result_ptr  <= result_pick + 1'b1;
				vertex_done <= vertex_done + 1'b1;
				edge_done   <= edge_done + count_t'(res_degree[result_pick]);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (result_fire) begin
			result_id <= res_id[result_pick];
			result    <= res_sum[result_pick];
		end
	end

endmodule

// ==== cu_io_regs.sv ====
`timescale 1ns/10ps
/* Input and output register stage
   Gates inputs with the enable and latches the result base address */
module cu_io_regs #(
	parameter  int NUM_VERTEX_CU = graph_cu_pkg::NUM_VERTEX_CU_DEFAULT,
	localparam int TAG_W         = $clog2(NUM_VERTEX_CU)
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled_in,
	input  logic [63:0]                cu_configure,
	input  logic                       vertex_job_valid,
	input  graph_cu_pkg::vertex_id_t   vertex_job_id,
	input  graph_cu_pkg::degree_t      vertex_job_degree,
	input  graph_cu_pkg::addr_t        vertex_job_edge_base,
	input  logic                       read_command_bus_grant,
	input  logic                       read_data_valid,
	input  logic [TAG_W-1:0]           read_data_tag,
	input  graph_cu_pkg::edge_data_t   read_data,
	output logic                       enabled,
	output graph_cu_pkg::addr_t        config_base,
	output graph_cu_pkg::vertex_job_t  job,
	output logic                       job_valid,
	output logic                       read_grant,
	output logic                       data_valid,
	output logic [TAG_W-1:0]           data_tag,
	output graph_cu_pkg::edge_data_t   data,
	input  logic                       job_request,
	input  logic                       read_bus_request,
	input  logic                       read_valid,
	input  graph_cu_pkg::addr_t        read_address,
	input  logic [TAG_W-1:0]           read_tag,
	input  logic                       result_write_valid,
	input  graph_cu_pkg::addr_t        result_write_address,
	input  graph_cu_pkg::result_t      result_write_data,
	input  graph_cu_pkg::count_t       vertex_done,
	input  graph_cu_pkg::count_t       edge_done,
	output logic                       vertex_job_request,
	output logic                       read_command_bus_request,
	output logic                       read_command_valid,
	output graph_cu_pkg::addr_t        read_command_address,
	output logic [TAG_W-1:0]           read_command_tag,
	output logic                       write_command_valid,
	output graph_cu_pkg::addr_t        write_command_address,
	output graph_cu_pkg::result_t      write_data,
	output graph_cu_pkg::count_t       vertex_job_counter_done,
	output graph_cu_pkg::count_t       edge_job_counter_done
);

	////////////////////////////////////////////////////////////////////////////
	// Input side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			job_valid   <= 1'b0;
			read_grant  <= 1'b0;
			data_valid  <= 1'b0;
			config_base <= '0;
		end else begin
			enabled    <= enabled_in;
			// Strobes pass only while enabled
			job_valid  <= enabled & vertex_job_valid;
			read_grant <= enabled & read_command_bus_grant;
			data_valid <= enabled & read_data_valid;
			// A zero word keeps the previous base
			if (enabled && (|cu_configure)) begin
				config_base <= cu_configure[31:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		job.id        <= vertex_job_id;
		job.degree    <= vertex_job_degree;
		job.edge_base <= vertex_job_edge_base;
		data_tag      <= read_data_tag;
		data          <= read_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output side
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_request       <= 1'b0;
			read_command_bus_request <= 1'b0;
			read_command_valid       <= 1'b0;
			write_command_valid      <= 1'b0;
			vertex_job_counter_done  <= '0;
			edge_job_counter_done    <= '0;
		end else begin
			vertex_job_request       <= job_request;
			read_command_bus_request <= read_bus_request;
			read_command_valid       <= read_valid;
			write_command_valid      <= result_write_valid;
			vertex_job_counter_done  <= vertex_done;
			edge_job_counter_done    <= edge_done;
		end
	end

	always_ff @(posedge clock) begin
		read_command_address  <= read_address;
		read_command_tag      <= read_tag;
		write_command_address <= result_write_address;
		write_data            <= result_write_data;
	end

endmodule

// ==== vertex_port_if.sv ====
`timescale 1ns/10ps
/* Link between the arbiter control and one vertex unit */
interface vertex_port_if;
	import graph_cu_pkg::*;

	// Arbiter to unit
	logic        job_valid;
	vertex_job_t job;
	logic        read_grant;
	logic        data_valid;
	edge_data_t  data;
	logic        result_grant;

	// Unit to arbiter
	logic       idle;
	logic       read_valid;
	addr_t      read_address;
	logic       result_valid;
	result_t    result;
	vertex_id_t result_id;
	degree_t    result_degree;

	modport arbiter (
		output job_valid, job, read_grant, data_valid, data, result_grant,
		input  idle, read_valid, read_address, result_valid, result, result_id,
		       result_degree
	);

	modport unit (
		input  job_valid, job, read_grant, data_valid, data, result_grant,
		output idle, read_valid, read_address, result_valid, result, result_id,
		       result_degree
	);

endinterface

// ==== graph_cu_pkg.sv ====
/* Graph compute unit shared definitions
   Widths, the vertex job record and the vertex unit states */
package graph_cu_pkg;

	// Default number of vertex units
	parameter int NUM_VERTEX_CU_DEFAULT = 4;

	////////////////////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] addr_t;
	typedef logic [15:0] vertex_id_t;
	typedef logic [7:0]  degree_t;
	typedef logic [15:0] edge_data_t;
	typedef logic [31:0] result_t;
	typedef logic [31:0] count_t;

	// One vertex job, 56 bits
	typedef struct packed {
		vertex_id_t id;
		degree_t    degree;
		addr_t      edge_base;
	} vertex_job_t;

	// Vertex unit FSM
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DRAIN,
		RESULT
	} vertex_state_e;

endpackage
